// File: Makefile
VERILATOR ?= verilator
TOP       ?= video_out_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
logic/video_timing_pkg.sv
logic/pixel_pkg.sv
logic/pixel_capture.sv
logic/line_buffer_ram.sv
logic/video_timing.sv
logic/video_out_top.sv
testbench/video_out_tb.sv

// File: logic/line_buffer_ram.sv
`default_nettype none

module line_buffer_ram #(
    parameter int line_length  = 320,
    parameter int buffer_lines = 16,
    parameter int address_bits = 13
) (
    input  wire logic                     clock,
    input  wire pixel_pkg::buffer_write_t buffer_write,
    input  wire logic [address_bits-1:0]  read_address,
    output pixel_pkg::rgb_t               read_data
);

    localparam int depth = line_length * buffer_lines;

    pixel_pkg::rgb_t memory [depth];

    logic [address_bits-1:0] address_q;

    // write port
    always_ff @(posedge clock) begin
        if (buffer_write.enable) begin
            memory[buffer_write.address[address_bits-1:0]] <= buffer_write.data;
        end
    end

    // read port, address then data registered
    always_ff @(posedge clock) begin
        address_q <= read_address;
        read_data <= memory[address_q];
    end

endmodule

`default_nettype wire

// File: logic/pixel_capture.sv
`default_nettype none

module pixel_capture #(
    parameter int line_length  = 320,
    parameter int buffer_lines = 16,
    parameter int start_lines  = 8
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire pixel_pkg::rgb_t   source_pixel,
    input  wire logic              source_valid,
    input  wire logic              source_line_start,
    input  wire logic              source_frame_start,
    output pixel_pkg::buffer_write_t buffer_write,
    output logic                   start_trigger
);

    localparam int aw = pixel_pkg::buffer_address_bits;

    localparam logic [aw-1:0] column_count = aw'(line_length);
    localparam logic [aw-1:0] last_column  = aw'(line_length - 1);
    localparam logic [aw-1:0] last_ring    = aw'(buffer_lines - 1);
    localparam logic [aw-1:0] trigger_line = aw'(start_lines - 1);

    logic [aw-1:0] column;
    logic [aw-1:0] line_count;  // line within the source frame
    logic [aw-1:0] ring_line;   // line count mod buffer_lines
    logic          line_open;   // first line_start of a frame only opens line 0
    logic          pixel_taken;
    logic          last_pixel_q;

    logic            write_enable;
    logic [aw-1:0]   write_address;
    pixel_pkg::rgb_t write_data;
    logic [aw-1:0]   next_address;

    assign pixel_taken = source_valid && (column < column_count); // extra pixels dropped

    always_comb begin
        next_address = aw'(int'(ring_line) * line_length + int'(column));
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            column        <= '0;
            line_count    <= '0;
            ring_line     <= '0;
            line_open     <= 1'b0;
            write_enable  <= 1'b0;
            last_pixel_q  <= 1'b0;
            start_trigger <= 1'b0;
        end else begin
            write_enable <= pixel_taken;
            last_pixel_q <= pixel_taken && (column == last_column) && (line_count == trigger_line);
            if (last_pixel_q) begin
                start_trigger <= 1'b1; // held until reset
            end

            if (source_frame_start) begin
                column     <= '0;
                line_count <= '0;
                ring_line  <= '0;
                line_open  <= source_line_start;
            end else if (source_line_start) begin
                column    <= '0;
                line_open <= 1'b1;
                if (line_open) begin
                    line_count <= line_count + 1'b1;
                    ring_line  <= (ring_line == last_ring) ? '0 : ring_line + 1'b1;
                end
            end else if (pixel_taken) begin
                column <= column + 1'b1;
            end
        end
    end

    // pixel payload
    always_ff @(posedge clock) begin
        write_address <= next_address;
        write_data    <= source_pixel;
    end

    assign buffer_write = '{enable: write_enable, address: write_address, data: write_data};

    write_in_ring: assert property (@(posedge clock) disable iff (!reset)
        write_enable |-> (int'(write_address) < line_length * buffer_lines));

endmodule

`default_nettype wire

// File: logic/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    localparam int buffer_address_bits = 16;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // one pixel into the line ring
    typedef struct packed {
        logic                           enable;
        logic [buffer_address_bits-1:0] address;
        rgb_t                           data;
    } buffer_write_t;

endpackage

`default_nettype wire

// File: logic/video_out_top.sv
`default_nettype none

module video_out_top #(
    parameter int h_total      = 858,
    parameter int h_visible    = 720,
    parameter int h_sync_start = 736,
    parameter int h_sync_width = 62,
    parameter int h_offset     = 40,
    parameter int v_total      = 262,
    parameter int v_visible    = 240,
    parameter int v_sync_start = 244,
    parameter int v_sync_width = 3,
    parameter int v_offset     = 0,
    parameter int line_length  = 320,
    parameter int buffer_lines = 16,
    parameter int start_lines  = 8,
    parameter int address_bits = 13
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire pixel_pkg::rgb_t               source_pixel,
    input  wire logic                          source_valid,
    input  wire logic                          source_line_start,
    input  wire logic                          source_frame_start,
    input  wire video_timing_pkg::video_mode_t mode,
    output pixel_pkg::rgb_t                    rgb,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               draw_area,
    output logic                               field
);

    pixel_pkg::buffer_write_t buffer_write;
    pixel_pkg::rgb_t          read_data;
    logic [address_bits-1:0]  read_address;
    logic                     start_trigger;

    pixel_capture #(
        .line_length (line_length),
        .buffer_lines(buffer_lines),
        .start_lines (start_lines)
    ) pixel_capture_i (
        .clock             (clock),
        .reset             (reset),
        .source_pixel      (source_pixel),
        .source_valid      (source_valid),
        .source_line_start (source_line_start),
        .source_frame_start(source_frame_start),
        .buffer_write      (buffer_write),
        .start_trigger     (start_trigger)
    );

    line_buffer_ram #(
        .line_length (line_length),
        .buffer_lines(buffer_lines),
        .address_bits(address_bits)
    ) line_buffer_ram_i (
        .clock       (clock),
        .buffer_write(buffer_write),
        .read_address(read_address),
        .read_data   (read_data)
    );

    video_timing #(
        .h_total     (h_total),
        .h_visible   (h_visible),
        .h_sync_start(h_sync_start),
        .h_sync_width(h_sync_width),
        .h_offset    (h_offset),
        .v_total     (v_total),
        .v_visible   (v_visible),
        .v_sync_start(v_sync_start),
        .v_sync_width(v_sync_width),
        .v_offset    (v_offset),
        .line_length (line_length),
        .buffer_lines(buffer_lines),
        .address_bits(address_bits)
    ) video_timing_i (
        .clock        (clock),
        .reset        (reset),
        .start_trigger(start_trigger),
        .mode         (mode),
        .read_data    (read_data),
        .read_address (read_address),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync),
        .draw_area    (draw_area),
        .field        (field)
    );

endmodule

`default_nettype wire

// File: logic/video_timing.sv
`default_nettype none

module video_timing #(
    parameter int h_total      = 858,
    parameter int h_visible    = 720,
    parameter int h_sync_start = 736,
    parameter int h_sync_width = 62,
    parameter int h_offset     = 40,
    parameter int v_total      = 262,
    parameter int v_visible    = 240,
    parameter int v_sync_start = 244,
    parameter int v_sync_width = 3,
    parameter int v_offset     = 0,
    parameter int line_length  = 320,
    parameter int buffer_lines = 16,
    parameter int address_bits = 13
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         start_trigger,
    input  wire video_timing_pkg::video_mode_t mode,
    input  wire pixel_pkg::rgb_t              read_data,
    output logic [address_bits-1:0]           read_address,
    output pixel_pkg::rgb_t                   rgb,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              draw_area,
    output logic                              field
);

    localparam int x_bits = $clog2(h_total);
    localparam int y_bits = $clog2(v_total + 1); // room for the added line
    localparam int run_bits = $clog2(h_total + 1);

    localparam logic [x_bits-1:0] x_start = x_bits'(h_offset);
    localparam logic [y_bits-1:0] y_start = y_bits'(v_offset);
    localparam logic [x_bits-1:0] x_last  = x_bits'(h_total - 1);

    video_timing_pkg::timing_state_e state;
    video_timing_pkg::video_mode_t   mode_q;
    video_timing_pkg::scan_mode_e    scan_mode;

    logic [x_bits-1:0] x_count;
    logic [y_bits-1:0] y_count;
    logic [x_bits-1:0] x_q;
    logic [y_bits-1:0] y_q;
    logic [y_bits-1:0] y_last;

    int x_pos;
    int y_pos;
    int x_pos_q;
    int y_pos_q;

    logic window_now;
    logic draw_now;
    logic window_q;
    logic window_q_q;
    logic draw_q;
    logic draw_q_q;
    logic hsync_next;
    logic vsync_next;
    logic hsync_q;
    logic vsync_q;
    logic field_q;

    logic [run_bits-1:0] hsync_run; // length of the current sync pulse

    // inset analog picture
    function automatic logic in_window(input int x, input int y);
        return x >= h_offset && x < h_visible - h_offset
            && y >= v_offset && y < v_visible - v_offset;
    endfunction

    function automatic logic in_draw(input int x, input int y);
        return x < h_visible && y < v_visible;
    endfunction

    always_comb begin
        if (!mode_q.line_doubler) begin
            scan_mode = video_timing_pkg::mode_progressive;
        end else if (mode_q.add_line) begin
            scan_mode = video_timing_pkg::mode_doubled_240p;
        end else begin
            scan_mode = video_timing_pkg::mode_interlaced_480i;
        end
        y_last = mode_q.add_line ? y_bits'(v_total) : y_bits'(v_total - 1);
    end

    always_comb begin
        x_pos      = int'(x_count);
        y_pos      = int'(y_count);
        window_now = in_window(x_pos, y_pos);
        draw_now   = in_draw(x_pos, y_pos);
        read_address = '0;
        if (window_now) begin
            read_address = address_bits'(((y_pos / 2 - v_offset / 2) % buffer_lines) * line_length
                                         + (x_pos / 2 - h_offset / 2));
        end
    end

    // syncs from the once-delayed position
    always_comb begin
        x_pos_q    = int'(x_q);
        y_pos_q    = int'(y_q);
        hsync_next = !video_timing_pkg::hsync_active;
        vsync_next = !video_timing_pkg::vsync_active;
        if (x_pos_q >= h_sync_start && x_pos_q < h_sync_start + h_sync_width) begin
            hsync_next = video_timing_pkg::hsync_active;
        end
        // one extra line so vsync ends on the hsync edge
        if (y_pos_q >= v_sync_start && y_pos_q <= v_sync_start + v_sync_width) begin
            if (!((y_pos_q == v_sync_start && x_pos_q < h_sync_start)
                  || (y_pos_q == v_sync_start + v_sync_width && x_pos_q >= h_sync_start))) begin
                vsync_next = video_timing_pkg::vsync_active;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= video_timing_pkg::idle;
            mode_q     <= mode;
            x_count    <= x_start;
            y_count    <= y_start;
            x_q        <= '0;
            y_q        <= '0;
            window_q   <= 1'b0;
            window_q_q <= 1'b0;
            draw_q     <= 1'b0;
            draw_q_q   <= 1'b0;
            hsync_q    <= !video_timing_pkg::hsync_active;
            vsync_q    <= !video_timing_pkg::vsync_active;
            field_q    <= 1'b0;
        end else begin
            mode_q <= mode;
            if (mode != mode_q) begin
                // resync, restart on the (already high) trigger
                state      <= video_timing_pkg::idle;
                x_count    <= x_start;
                y_count    <= y_start;
                window_q   <= 1'b0;
                window_q_q <= 1'b0;
                draw_q     <= 1'b0;
                draw_q_q   <= 1'b0;
                hsync_q    <= !video_timing_pkg::hsync_active;
                vsync_q    <= !video_timing_pkg::vsync_active;
                field_q    <= 1'b0;
            end else if (state == video_timing_pkg::idle) begin
                if (start_trigger) begin
                    state   <= video_timing_pkg::running;
                    x_count <= x_start;
                    y_count <= y_start;
                end
            end else begin
                if (x_count != x_last) begin
                    x_count <= x_count + 1'b1;
                end else begin
                    x_count <= '0;
                    if (y_count != y_last) begin
                        y_count <= y_count + 1'b1;
                    end else begin
                        y_count <= '0;
                        field_q <= (scan_mode == video_timing_pkg::mode_interlaced_480i)
                                   ? !field_q : 1'b0;
                    end
                end

                x_q        <= x_count;
                y_q        <= y_count;
                window_q   <= window_now;
                window_q_q <= window_q; // lines up with read_data
                draw_q     <= draw_now;
                draw_q_q   <= draw_q;
                hsync_q    <= hsync_next;
                vsync_q    <= vsync_next;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset || hsync_q != video_timing_pkg::hsync_active) begin
            hsync_run <= '0;
        end else begin
            hsync_run <= hsync_run + 1'b1;
        end
    end

    assign rgb       = window_q_q ? read_data : '0; // black outside the window
    assign hsync     = hsync_q;
    assign vsync     = vsync_q;
    assign draw_area = draw_q_q;
    assign field     = field_q;

    hsync_pulse_width: assert property (@(posedge clock) disable iff (!reset)
        int'(hsync_run) <= h_sync_width);

    read_in_ring: assert property (@(posedge clock) disable iff (!reset)
        int'(read_address) < line_length * buffer_lines);

endmodule

`default_nettype wire

// File: logic/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

    // how the source is shown
    typedef enum logic [1:0] {
        mode_progressive     = 2'd0, // doubler off
        mode_doubled_240p    = 2'd1, // doubler on, extra line
        mode_interlaced_480i = 2'd2  // doubler on, field toggles
    } scan_mode_e;

    // level inputs, any change restarts the display counters
    typedef struct packed {
        logic line_doubler;
        logic add_line;
    } video_mode_t;

    typedef enum logic {
        idle    = 1'b0, // waiting for start trigger
        running = 1'b1
    } timing_state_e;

    // output standard, both syncs active low
    localparam logic hsync_active = 1'b0;
    localparam logic vsync_active = 1'b0;

endpackage

`default_nettype wire

// File: testbench/video_out_tb.sv
`default_nettype none

module video_out_tb;

    localparam int h_total      = 40;
    localparam int h_visible    = 32;
    localparam int h_sync_start = 34;
    localparam int h_sync_width = 3;
    localparam int h_offset     = 4;
    localparam int v_total      = 20;
    localparam int v_visible    = 16;
    localparam int v_sync_start = 17;
    localparam int v_sync_width = 2;
    localparam int v_offset     = 2;
    localparam int line_length  = 12;
    localparam int buffer_lines = 8;
    localparam int start_lines  = 7;
    localparam int address_bits = 7;

    localparam int clock_period = 20;
    localparam int drive_delay  = 2;
    localparam int pixel_count  = start_lines * line_length;
    localparam int probe_count  = 19;
    localparam int check_frames = 3;                        // full frames after the partial one
    localparam int frame_cycles = h_total * (v_total + 1);  // longest frame
    localparam int load_cycles  = start_lines * (1 + 3 * line_length) + 20;
    localparam int timeout      = (load_cycles + 3 * 4 * frame_cycles) * clock_period;

    logic                          clock;
    logic                          reset;
    pixel_pkg::rgb_t               source_pixel;
    logic                          source_valid;
    logic                          source_line_start;
    logic                          source_frame_start;
    video_timing_pkg::video_mode_t mode;
    pixel_pkg::rgb_t               rgb;
    logic                          hsync;
    logic                          vsync;
    logic                          draw_area;
    logic                          field;

    logic [47:0] vector_words [pixel_count + probe_count]; // pixels, then probes
    logic        probe_seen [probe_count];
    logic        source_loaded;

    video_out_top #(
        .h_total     (h_total),
        .h_visible   (h_visible),
        .h_sync_start(h_sync_start),
        .h_sync_width(h_sync_width),
        .h_offset    (h_offset),
        .v_total     (v_total),
        .v_visible   (v_visible),
        .v_sync_start(v_sync_start),
        .v_sync_width(v_sync_width),
        .v_offset    (v_offset),
        .line_length (line_length),
        .buffer_lines(buffer_lines),
        .start_lines (start_lines),
        .address_bits(address_bits)
    ) video_out_top_i (.*);

    always #(clock_period / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_drive_slot();
        @(posedge clock);
        #drive_delay;
    endtask

    function automatic video_timing_pkg::video_mode_t mode_levels(
        input video_timing_pkg::scan_mode_e scan);
        video_timing_pkg::video_mode_t levels;
        levels.line_doubler = (scan != video_timing_pkg::mode_progressive);
        levels.add_line     = (scan == video_timing_pkg::mode_doubled_240p);
        return levels;
    endfunction

    // each source pixel shown as a 2x2 block inside the inset window
    function automatic pixel_pkg::rgb_t expected_pixel(input int x, input int y);
        int line;
        int column;
        if (x < h_offset || x >= h_visible - h_offset || y < v_offset
            || y >= v_visible - v_offset) begin
            return '0;
        end
        line   = (y - v_offset) / 2;
        column = (x - h_offset) / 2;
        return vector_words[line * line_length + column][23:0];
    endfunction

    task automatic load_source();
        wait_drive_slot();
        source_frame_start = 1'b1;
        wait_drive_slot();
        source_frame_start = 1'b0;
        for (int line = 0; line < start_lines; line++) begin
            source_line_start = 1'b1;
            wait_drive_slot();
            source_line_start = 1'b0;
            for (int column = 0; column < line_length; column++) begin
                repeat ($urandom % 3) wait_drive_slot(); // idle gap
                source_pixel = vector_words[line * line_length + column][23:0];
                source_valid = 1'b1;
                wait_drive_slot();
                source_valid = 1'b0;
            end
        end
        source_loaded = 1'b1;
    endtask

    task automatic check_idle();
        while (!source_loaded) begin
            @(negedge clock);
            check_value("hsync", hsync, 1'b1);
            check_value("vsync", vsync, 1'b1);
            check_value("draw_area", draw_area, 1'b0);
            check_value("rgb", rgb, 24'h0);
            check_value("field", field, 1'b0);
        end
    endtask

    task automatic check_probes(input video_timing_pkg::scan_mode_e scan, input int x,
                                input int y);
        logic [47:0] probe;
        for (int i = 0; i < probe_count; i++) begin
            probe = vector_words[pixel_count + i];
            if (int'(probe[43:40]) == int'(scan) && int'(probe[39:32]) == x
                && int'(probe[31:24]) == y) begin
                check_value("rgb at probe", rgb, probe[23:0]);
                probe_seen[i] = 1'b1;
            end
        end
    endtask

    task automatic run_phase(input video_timing_pkg::scan_mode_e scan);
        int   x;
        int   y;
        int   frame;
        int   lines;
        int   last_frame;
        logic expect_field;
        logic expect_hsync;
        logic expect_vsync;
        wait_drive_slot();
        mode  = mode_levels(scan);
        lines = (scan == video_timing_pkg::mode_doubled_240p) ? v_total + 1 : v_total;
        // odd number of frame ends in 480i, so field is set when the mode changes back
        last_frame = (scan == video_timing_pkg::mode_interlaced_480i)
                     ? check_frames - 1 : check_frames;
        @(negedge clock);
        while (draw_area) begin
            @(negedge clock);
        end
        while (!draw_area) begin
            @(negedge clock);
        end
        // first draw cycle is the offset position
        x            = h_offset;
        y            = v_offset;
        frame        = 0;
        expect_field = 1'b0;
        while (frame <= last_frame) begin
            expect_hsync = !(x >= h_sync_start && x < h_sync_start + h_sync_width);
            expect_vsync = !((y == v_sync_start && x >= h_sync_start)
                             || (y > v_sync_start && y < v_sync_start + v_sync_width)
                             || (y == v_sync_start + v_sync_width && x < h_sync_start));
            check_value("hsync", hsync, expect_hsync);
            check_value("vsync", vsync, expect_vsync);
            check_value("draw_area", draw_area, x < h_visible && y < v_visible);
            check_value("rgb", rgb, expected_pixel(x, y));
            if (x == 8) begin
                check_value("field", field, expect_field); // mid-line sample
            end
            check_probes(scan, x, y);
            @(negedge clock);
            x++;
            if (x == h_total) begin
                x = 0;
                y++;
                if (y == lines) begin
                    y = 0;
                    frame++;
                    if (scan == video_timing_pkg::mode_interlaced_480i) begin
                        expect_field = !expect_field;
                    end
                end
            end
        end
    endtask

    initial begin
        int missed;
        clock              = 1'b0;
        reset              = 1'b0;
        source_pixel       = '0;
        source_valid       = 1'b0;
        source_line_start  = 1'b0;
        source_frame_start = 1'b0;
        mode               = mode_levels(video_timing_pkg::mode_doubled_240p);
        source_loaded      = 1'b0;
        missed             = 0;
        void'($urandom(32'hdb229be7));
        $readmemh("testbench/video_out_vectors.txt", vector_words);
        foreach (probe_seen[i]) begin
            probe_seen[i] = 1'b0;
        end
        repeat (4) @(posedge clock);
        #drive_delay;
        reset = 1'b1;
        fork
            load_source();
            check_idle();
        join
        run_phase(video_timing_pkg::mode_doubled_240p);
        run_phase(video_timing_pkg::mode_interlaced_480i);
        run_phase(video_timing_pkg::mode_doubled_240p); // restart after 480i
        foreach (probe_seen[i]) begin
            if (!probe_seen[i]) begin
                missed++;
            end
        end
        if (missed == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d probe positions were never reached on the display", missed);
            $display("Test failed");
            $fatal(1, "probes not reached");
        end
    end

    // watchdog
    initial begin
        #(timeout);
        $display("Run timed out before all display phases finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: testbench/video_out_vectors.txt
// source frame: 7 lines of 12 pixels, each word rrggbb
// probes: 0, mode, x, y (two hex digits each), expected rgb as rrggbb
0000d0 0110d1 0220d2 0330d3 0440d4 0550d5 0660d6 0770d7 0880d8 0990d9 0aa0da 0bb0db
1001d0 1111d1 1221d2 1331d3 1441d4 1551d5 1661d6 1771d7 1881d8 1991d9 1aa1da 1bb1db
2002d0 2112d1 2222d2 2332d3 2442d4 2552d5 2662d6 2772d7 2882d8 2992d9 2aa2da 2bb2db
3003d0 3113d1 3223d2 3333d3 3443d4 3553d5 3663d6 3773d7 3883d8 3993d9 3aa3da 3bb3db
4004d0 4114d1 4224d2 4334d3 4444d4 4554d5 4664d6 4774d7 4884d8 4994d9 4aa4da 4bb4db
5005d0 5115d1 5225d2 5335d3 5445d4 5555d5 5665d6 5775d7 5885d8 5995d9 5aa5da 5bb5db
6006d0 6116d1 6226d2 6336d3 6446d4 6556d5 6666d6 6776d7 6886d8 6996d9 6aa6da 6bb6db
0104020000d0
0105030000d0
0106020110d1
011b0d5bb5db
011a0c5bb5db
010302000000
011c05000000
010a0e000000
010a01000000
010f072552d5
0114093883d8
010d0b4444d4
012311000000
010514000000
0208041221d2
02150a4884d8
0218062aa2da
020000000000
021b020bb0db
